// ==== hw/sw_pkg.sv ====
// Shared types and constants of the alignment accelerator, referenced by scoped names
package sw_pkg;

  // Nucleotide coding
  typedef logic [1:0] base_t;

  localparam base_t BASE_A = 2'd0;
  localparam base_t BASE_G = 2'd1;
  localparam base_t BASE_T = 2'd2;
  localparam base_t BASE_C = 2'd3;

  // Gap of k bases costs GAP_OPEN_PEN + (k - 1) * GAP_EXT_PEN
  localparam int MATCH_SCORE  = 5;     // Same base on both sides
  localparam int MISMATCH_PEN = -4;    // Substitution
  localparam int GAP_OPEN_PEN = -12;   // First base of a gap
  localparam int GAP_EXT_PEN  = -4;    // Every further gap base

  localparam int SCORE_W = 12;         // Local scores never go negative

  typedef logic [SCORE_W-1:0] score_t;

  // Descriptor layout, length on top and packed bases below
  localparam int DESC_W    = 64;
  localparam int LEN_W     = 16;
  localparam int SEQ_BYTES = 6;
  localparam int MAX_BASES = SEQ_BYTES * 4;  // Four bases per byte

  typedef struct packed {
    logic              valid;  // Single-cycle strobe
    logic [DESC_W-1:0] data;   // Raw word as it arrives
  } desc_t;

  typedef struct packed {
    logic [LEN_W-1:0]       len;    // Base count
    logic [SEQ_BYTES*8-1:0] bases;  // Base 0 in the top two bits
  } desc_fields_t;

  typedef struct packed {
    logic start;          // Job strobe
    logic little_endian;  // Byte order of the following descriptors
  } job_t;

  // Link between neighbouring array cells
  typedef struct packed {
    logic   valid;  // Base present this cycle
    logic   last;   // Final base of the target, or the empty-target marker
    base_t  base;   // Target base
    score_t h;      // H of the upstream cell for this base
    score_t f;      // F of the upstream cell for this base
  } pe_link_t;

  typedef struct packed {
    logic   valid;  // Single-cycle strobe
    score_t score;  // Best local score
  } result_t;

endpackage

// ==== hw/sw_cell.sv ====
// Systolic element that scores its query base against each target base passing through
`timescale 1ns/1ps

module sw_cell (
  input  logic             ha_pclock,
  input  logic             reset,
  input  logic             clear,       // Start of a new target
  input  sw_pkg::base_t    query_base,  // Query base held by this cell
  input  logic             enabled,     // Cell lies inside the query length
  input  sw_pkg::pe_link_t link_in,     // From upstream cell or feed
  output sw_pkg::pe_link_t link_out,    // To downstream cell
  output sw_pkg::score_t   h_score      // Latest H of this cell
);

  localparam int SW = sw_pkg::SCORE_W + 2;  // Signed working width

  logic signed [SW-1:0] sub_score;  // Match or mismatch
  logic signed [SW-1:0] diag_sum;
  logic signed [SW-1:0] e_cand;
  logic signed [SW-1:0] f_cand;
  logic signed [SW-1:0] h_cand;
  sw_pkg::score_t       e_next;
  sw_pkg::score_t       f_next;
  sw_pkg::score_t       h_next;
  sw_pkg::score_t       h_r;        // H(i, j-1)
  sw_pkg::score_t       e_r;        // E(i, j-1)
  sw_pkg::score_t       diag_r;     // H(i-1, j-1), upstream H of previous base
  sw_pkg::pe_link_t     link_r;

  function automatic logic signed [SW-1:0] widen(input sw_pkg::score_t s);
    return $signed({2'b00, s});
  endfunction

  function automatic logic signed [SW-1:0] smax(input logic signed [SW-1:0] a,
                                                input logic signed [SW-1:0] b);
    return (a > b) ? a : b;
  endfunction

  // Negative candidates never beat the zero floor of H
  function automatic sw_pkg::score_t floor0(input logic signed [SW-1:0] v);
    return (v < 0) ? '0 : v[sw_pkg::SCORE_W-1:0];
  endfunction

  always_comb
  begin
    sub_score = (query_base == link_in.base) ? SW'(sw_pkg::MATCH_SCORE)
                                             : SW'(sw_pkg::MISMATCH_PEN);
    diag_sum  = widen(diag_r) + sub_score;
    // Gap along the target, own previous column
    e_cand    = smax(widen(h_r) + SW'(sw_pkg::GAP_OPEN_PEN),
                     widen(e_r) + SW'(sw_pkg::GAP_EXT_PEN));
    // Gap along the query, from the cell above
    f_cand    = smax(widen(link_in.h) + SW'(sw_pkg::GAP_OPEN_PEN),
                     widen(link_in.f) + SW'(sw_pkg::GAP_EXT_PEN));
    h_cand    = smax(diag_sum, smax(e_cand, f_cand));
    e_next    = enabled ? floor0(e_cand) : '0;  // Cells past the query stay at zero
    f_next    = enabled ? floor0(f_cand) : '0;
    h_next    = enabled ? floor0(h_cand) : '0;
  end

  // Recurrence state, restarted for every target
  always_ff @(posedge ha_pclock)
  begin
    if (reset || clear)
    begin
      h_r    <= '0;
      e_r    <= '0;
      diag_r <= '0;
    end
    else if (link_in.valid)
    begin
      h_r    <= h_next;
      e_r    <= e_next;
      diag_r <= link_in.h;  // Becomes the diagonal for the next base
    end
  end

  // One register stage toward the next cell
  always_ff @(posedge ha_pclock)
  begin
    if (reset)
    begin
      link_r.valid <= 1'b0;
      link_r.last  <= 1'b0;
    end
    else
    begin
      link_r.valid <= link_in.valid;
      link_r.last  <= link_in.last;  // Travels even without a base
      link_r.base  <= link_in.base;
      link_r.h     <= h_next;
      link_r.f     <= f_next;
    end
  end

  assign link_out = link_r;
  assign h_score  = h_r;

endmodule

// ==== hw/sw_array.sv ====
// Systolic chain of scoring cells that tracks the best H and reports it after the last base
`timescale 1ns/1ps

module sw_array #(
  parameter int QUERY_LEN = 8  // Cells in the chain
) (
  input  logic                          ha_pclock,
  input  logic                          reset,
  input  logic                          clear,        // New target follows
  input  sw_pkg::base_t [QUERY_LEN-1:0] query_bases,  // Element k feeds cell k
  input  logic [QUERY_LEN-1:0]          query_mask,   // Cells inside the query
  input  sw_pkg::pe_link_t              feed,         // Target stream into cell 0
  output sw_pkg::result_t               result
);

  sw_pkg::pe_link_t links [QUERY_LEN+1];  // links[k] enters cell k
  sw_pkg::score_t   h_scores [QUERY_LEN];
  sw_pkg::score_t   cyc_max;              // Best H in this cycle
  sw_pkg::score_t   run_max;              // Best H so far
  sw_pkg::score_t   best;
  sw_pkg::result_t  result_r;

  assign links[0] = feed;

  for (genvar k = 0; k < QUERY_LEN; k++)
  begin : g_cell
    sw_cell u_cell (
      .ha_pclock  (ha_pclock),
      .reset      (reset),
      .clear      (clear),
      .query_base (query_bases[k]),
      .enabled    (query_mask[k]),
      .link_in    (links[k]),
      .link_out   (links[k+1]),
      .h_score    (h_scores[k])
    );
  end

  // Max over all cells, folded into the running max
  always_comb
  begin
    cyc_max = '0;
    for (int k = 0; k < QUERY_LEN; k++)
    begin
      if (h_scores[k] > cyc_max)
      begin
        cyc_max = h_scores[k];
      end
    end
    best = (cyc_max > run_max) ? cyc_max : run_max;
  end

  always_ff @(posedge ha_pclock)
  begin
    if (reset || clear)
    begin
      run_max <= '0;
    end
    else
    begin
      run_max <= best;
    end
  end

  // Last flag out of the final cell means every cell is done
  always_ff @(posedge ha_pclock)
  begin
    if (reset)
    begin
      result_r.valid <= 1'b0;
    end
    else
    begin
      result_r.valid <= links[QUERY_LEN].last;
      if (links[QUERY_LEN].last)
      begin
        result_r.score <= best;  // Includes the final cell's last H
      end
    end
  end

  assign result = result_r;

endmodule

// ==== hw/seq_sequencer.sv ====
// Job FSM that takes the query and target descriptors and streams the target into the array
`timescale 1ns/1ps

module seq_sequencer #(
  parameter int QUERY_LEN = 8  // Cells in the array
) (
  input  logic                          ha_pclock,
  input  logic                          reset,
  input  sw_pkg::job_t                  job,
  input  sw_pkg::desc_t                 desc,
  input  sw_pkg::result_t               result,       // From the array
  output logic                          busy,
  output sw_pkg::base_t [QUERY_LEN-1:0] query_bases,
  output logic [QUERY_LEN-1:0]          query_mask,
  output sw_pkg::pe_link_t              feed,
  output logic                          clear
);

  localparam int CNT_W = $clog2(sw_pkg::MAX_BASES + 1);  // Holds 0 to MAX_BASES
  localparam int SEQ_W = 8 * sw_pkg::SEQ_BYTES;          // Base field bits

  typedef enum logic [2:0] {
    S_IDLE,    // Waiting for a job strobe
    S_LOAD_Q,  // Query descriptor expected
    S_LOAD_T,  // Target descriptor expected
    S_FEED,    // Shifting bases out
    S_WAIT     // Array still draining
  } state_t;

  state_t               state;
  logic                 little_endian_r;  // Byte order of this job
  sw_pkg::desc_fields_t raw_fields;
  sw_pkg::desc_fields_t fields;           // After byte reordering
  logic [SEQ_W-1:0]     query_r;
  logic [SEQ_W-1:0]     target_r;         // Next base in the top two bits
  logic [CNT_W-1:0]     query_len_r;
  logic [CNT_W-1:0]     base_cnt;         // Target bases still to send
  logic                 clear_r;
  logic                 feed_valid_r;
  logic                 feed_last_r;
  sw_pkg::base_t        feed_base_r;

  function automatic logic [CNT_W-1:0] clamp_len(input logic [sw_pkg::LEN_W-1:0] len,
                                                 input int unsigned limit);
    if (len > limit)
    begin
      return CNT_W'(limit);
    end
    return CNT_W'(len);
  endfunction

  assign raw_fields = sw_pkg::desc_fields_t'(desc.data);

  // Each field reversed on its own
  always_comb
  begin
    fields = raw_fields;
    if (little_endian_r)
    begin
      for (int b = 0; b < sw_pkg::LEN_W / 8; b++)
      begin
        fields.len[8*b +: 8] = raw_fields.len[sw_pkg::LEN_W-8-8*b +: 8];
      end
      for (int b = 0; b < sw_pkg::SEQ_BYTES; b++)
      begin
        fields.bases[8*b +: 8] = raw_fields.bases[SEQ_W-8-8*b +: 8];
      end
    end
  end

  // Base k of the query sits at bits 47-2k down to 46-2k
  for (genvar k = 0; k < QUERY_LEN; k++)
  begin : g_query
    assign query_bases[k] = query_r[SEQ_W-1-2*k -: 2];
    assign query_mask[k]  = (query_len_r > k);
  end

  always_ff @(posedge ha_pclock)
  begin
    if (reset)
    begin
      state        <= S_IDLE;
      query_len_r  <= '0;
      base_cnt     <= '0;
      clear_r      <= 1'b0;
      feed_valid_r <= 1'b0;
      feed_last_r  <= 1'b0;
    end
    else
    begin
      clear_r      <= 1'b0;  // Pulses only
      feed_valid_r <= 1'b0;
      feed_last_r  <= 1'b0;
      case (state)
        S_IDLE:
          if (job.start)
          begin
            little_endian_r <= job.little_endian;
            state           <= S_LOAD_Q;
          end
        S_LOAD_Q:
          if (desc.valid)
          begin
            query_r     <= fields.bases;
            query_len_r <= clamp_len(fields.len, QUERY_LEN);  // QUERY_LEN never above 24
            state       <= S_LOAD_T;
          end
        S_LOAD_T:
          if (desc.valid)
          begin
            target_r <= fields.bases;
            base_cnt <= clamp_len(fields.len, sw_pkg::MAX_BASES);
            clear_r  <= 1'b1;  // Array restarts while FEED settles
            state    <= S_FEED;
          end
        S_FEED:
        begin
          // Empty target sends a lone last flag with no base
          feed_valid_r <= (base_cnt != '0);
          feed_last_r  <= (base_cnt <= 1);
          feed_base_r  <= target_r[SEQ_W-1 -: 2];
          target_r     <= target_r << 2;
          if (base_cnt != '0)
          begin
            base_cnt <= base_cnt - 1'b1;
          end
          if (base_cnt <= 1)
          begin
            state <= S_WAIT;
          end
        end
        S_WAIT:
          if (result.valid)
          begin
            state <= S_IDLE;
          end
        default:
          state <= S_IDLE;
      endcase
    end
  end

  assign feed  = '{valid: feed_valid_r, last: feed_last_r, base: feed_base_r, h: '0, f: '0};
  assign clear = clear_r;
  assign busy  = (state != S_IDLE) && !result.valid;  // Drops with the result strobe

endmodule

// ==== hw/sw_accel_top.sv ====
// Top level of the alignment accelerator joining the job sequencer to the systolic array
`timescale 1ns/1ps

module sw_accel_top #(
  parameter int QUERY_LEN = 8  // Array cells, 1 to 24
) (
  input  logic            ha_pclock,
  input  logic            reset,
  input  sw_pkg::job_t    job,     // Start strobe and byte order
  input  sw_pkg::desc_t   desc,    // Query then target
  output sw_pkg::result_t result,  // Score strobe
  output logic            busy
);

  sw_pkg::base_t [QUERY_LEN-1:0] query_bases;
  logic [QUERY_LEN-1:0]          query_mask;
  sw_pkg::pe_link_t              feed;
  logic                          clear;

  seq_sequencer #(
    .QUERY_LEN (QUERY_LEN)
  ) u_sequencer (
    .ha_pclock   (ha_pclock),
    .reset       (reset),
    .job         (job),
    .desc        (desc),
    .result      (result),
    .busy        (busy),
    .query_bases (query_bases),
    .query_mask  (query_mask),
    .feed        (feed),
    .clear       (clear)
  );

  sw_array #(
    .QUERY_LEN (QUERY_LEN)
  ) u_array (
    .ha_pclock   (ha_pclock),
    .reset       (reset),
    .clear       (clear),
    .query_bases (query_bases),
    .query_mask  (query_mask),
    .feed        (feed),
    .result      (result)
  );

endmodule

// ==== bench/sw_ref_model.svh ====
// Reference scoring and descriptor packing for the accelerator testbench, included in its module
`ifndef SW_REF_MODEL_SVH
`define SW_REF_MODEL_SVH

typedef sw_pkg::base_t seq_t [sw_pkg::MAX_BASES];  // Base k of a sequence at index k

localparam int NEG_INF = -1000;  // Below any reachable score

function automatic int larger(input int a, input int b);
  return (a > b) ? a : b;
endfunction

// Letters A, G, T, C map to the two-bit codes, unused positions stay A
function automatic seq_t bases_from_text(input string txt);
  seq_t s;
  s = '{default: sw_pkg::BASE_A};
  for (int k = 0; k < txt.len() && k < sw_pkg::MAX_BASES; k++)
  begin
    case (txt[k])
      "G": s[k] = sw_pkg::BASE_G;
      "T": s[k] = sw_pkg::BASE_T;
      "C": s[k] = sw_pkg::BASE_C;
      default: s[k] = sw_pkg::BASE_A;
    endcase
  end
  return s;
endfunction

// Length on top, base k at bits 47-2k down to 46-2k, each field byte-reversed if little endian
function automatic logic [sw_pkg::DESC_W-1:0] pack_desc(input int len, input seq_t s,
                                                        input logic le);
  logic [sw_pkg::LEN_W-1:0]       len_f;
  logic [sw_pkg::SEQ_BYTES*8-1:0] base_f;
  logic [sw_pkg::LEN_W-1:0]       len_o;
  logic [sw_pkg::SEQ_BYTES*8-1:0] base_o;
  len_f = len[sw_pkg::LEN_W-1:0];
  for (int k = 0; k < sw_pkg::MAX_BASES; k++)
  begin
    base_f[47-2*k -: 2] = s[k];
  end
  len_o  = len_f;
  base_o = base_f;
  if (le)
  begin
    len_o = {len_f[7:0], len_f[15:8]};  // Two length bytes swapped
    for (int b = 0; b < sw_pkg::SEQ_BYTES; b++)
    begin
      base_o[8*b +: 8] = base_f[47-8*b -: 8];
    end
  end
  return {len_o, base_o};
endfunction

// Gotoh affine-gap local score after the length clamps
function automatic int local_score(input seq_t q, input int qlen_field, input seq_t t,
                                   input int tlen_field, input int cells);
  int qlen;
  int tlen;
  int best;
  int diag;
  int h [sw_pkg::MAX_BASES+1][sw_pkg::MAX_BASES+1];
  int e [sw_pkg::MAX_BASES+1][sw_pkg::MAX_BASES+1];  // Gap along the target
  int f [sw_pkg::MAX_BASES+1][sw_pkg::MAX_BASES+1];  // Gap along the query
  qlen = (qlen_field > sw_pkg::MAX_BASES) ? sw_pkg::MAX_BASES : qlen_field;
  qlen = (qlen > cells) ? cells : qlen;               // Only as many cells as the array
  tlen = (tlen_field > sw_pkg::MAX_BASES) ? sw_pkg::MAX_BASES : tlen_field;
  best = 0;
  for (int i = 0; i <= sw_pkg::MAX_BASES; i++)
  begin
    for (int j = 0; j <= sw_pkg::MAX_BASES; j++)
    begin
      h[i][j] = 0;
      e[i][j] = NEG_INF;
      f[i][j] = NEG_INF;
    end
  end
  for (int i = 1; i <= qlen; i++)
  begin
    for (int j = 1; j <= tlen; j++)
    begin
      diag    = h[i-1][j-1] + ((q[i-1] == t[j-1]) ? sw_pkg::MATCH_SCORE : sw_pkg::MISMATCH_PEN);
      e[i][j] = larger(h[i][j-1] + sw_pkg::GAP_OPEN_PEN, e[i][j-1] + sw_pkg::GAP_EXT_PEN);
      f[i][j] = larger(h[i-1][j] + sw_pkg::GAP_OPEN_PEN, f[i-1][j] + sw_pkg::GAP_EXT_PEN);
      h[i][j] = larger(0, larger(diag, larger(e[i][j], f[i][j])));  // Local floor
      best    = larger(best, h[i][j]);
    end
  end
  return best;
endfunction

`endif

// ==== bench/sw_accel_tb.sv ====
// Testbench of the alignment accelerator, run as top with the file list and checked by assertions
`timescale 1ns/1ps

module sw_accel_tb;

  localparam int CELLS       = 8;   // Array size of the DUT
  localparam int RESULT_WAIT = 40;  // Cycles allowed for a result

  logic            ha_pclock;
  logic            reset;
  sw_pkg::job_t    job;
  sw_pkg::desc_t   desc;
  sw_pkg::result_t result;
  logic            busy;

  int    seed;
  int    expected_score;   // Score the next result must carry
  logic  result_pending;   // A job is in flight
  string test_name;

  `include "sw_ref_model.svh"

  sw_accel_top #(
    .QUERY_LEN (CELLS)
  ) dut (
    .ha_pclock (ha_pclock),
    .reset     (reset),
    .job       (job),
    .desc      (desc),
    .result    (result),
    .busy      (busy)
  );

  always #5 ha_pclock = ~ha_pclock;  // 10 ns period

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Test failures found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  reset_quiet: assert property (@(posedge ha_pclock) $fell(reset) |-> !busy && !result.valid)
    else fail_run("busy or result.valid high right after reset");
  single_pulse: assert property (@(posedge ha_pclock) disable iff (reset)
    result.valid |=> !result.valid)
    else fail_run($sformatf("result.valid held longer than one cycle in %s", test_name));
  busy_drop: assert property (@(posedge ha_pclock) disable iff (reset)
    $fell(busy) |-> result.valid)
    else fail_run($sformatf("busy fell without a result strobe in %s", test_name));
  idle_on_result: assert property (@(posedge ha_pclock) disable iff (reset)
    result.valid |-> !busy)
    else fail_run($sformatf("busy still high with the result strobe in %s", test_name));
  busy_rise: assert property (@(posedge ha_pclock) disable iff (reset)
    (job.start && !busy && !result.valid) |=> busy)
    else fail_run($sformatf("busy did not rise after job start in %s", test_name));
  no_extra_result: assert property (@(posedge ha_pclock) disable iff (reset)
    result.valid |-> result_pending)
    else fail_run($sformatf("result strobe with no job in flight after %s", test_name));
  score_check: assert property (@(posedge ha_pclock) disable iff (reset)
    result.valid |-> int'(result.score) == expected_score)
    else fail_run($sformatf("MISMATCH %s expected %0d actual %0d", test_name, expected_score,
                            $sampled(result.score)));

  task automatic random_seq(output seq_t s);
    for (int k = 0; k < sw_pkg::MAX_BASES; k++)
    begin
      s[k] = sw_pkg::base_t'($unsigned($random(seed)) % 4);
    end
  endtask

  // Strobes during the feed phase, all of which the DUT must drop
  task automatic inject_strobes(input logic le);
    @(posedge ha_pclock);
    #1;
    job  = '{start: 1'b1, little_endian: !le};
    desc = '{valid: 1'b1, data: {$random(seed), $random(seed)}};
    @(posedge ha_pclock);
    #1;
    job       = '0;
    desc.data = {16'd3, 48'hFFFF_0000_FFFF};
    @(posedge ha_pclock);
    #1;
    desc = '0;
  endtask

  task automatic wait_for_result();
    int cycles;
    bit seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < RESULT_WAIT)
    begin
      @(posedge ha_pclock);
      #1;
      seen = result.valid;
      cycles++;
    end
    if (!seen)
    begin
      fail_run($sformatf("Timeout: no result within %0d cycles in %s", RESULT_WAIT, test_name));
    end
    else
    begin
      @(posedge ha_pclock);  // Pending stays up across the sampled strobe
      #1;
      result_pending = 1'b0;
    end
  endtask

  // Job strobe, query descriptor, target descriptor, then the result
  task automatic run_job(input string name, input seq_t q, input int qlen, input seq_t t,
                         input int tlen, input logic le, input int expected, input bit junk);
    test_name      = name;
    expected_score = expected;
    @(posedge ha_pclock);
    #1;
    job            = '{start: 1'b1, little_endian: le};
    result_pending = 1'b1;
    @(posedge ha_pclock);
    #1;
    job  = '0;
    desc = '{valid: 1'b1, data: pack_desc(qlen, q, le)};
    @(posedge ha_pclock);
    #1;
    desc.data = pack_desc(tlen, t, le);
    @(posedge ha_pclock);
    #1;
    desc = '0;
    if (junk)
    begin
      inject_strobes(le);
    end
    wait_for_result();
  endtask

  initial
  begin
    seq_t q;
    seq_t t;
    int   qlen;
    int   tlen;
    int   score;
    seed           = 32'h449c_8642;
    ha_pclock      = 1'b0;
    reset          = 1'b1;
    job            = '0;
    desc           = '0;
    result_pending = 1'b0;
    expected_score = 0;
    test_name      = "reset";
    repeat (8) @(posedge ha_pclock);
    #1;
    reset = 1'b0;

    q = bases_from_text("AGTCCATG");
    run_job("identical", q, 8, q, 8, 1'b0, 40, 1'b0);  // Eight matches at +5

    for (int n = 0; n < 20; n++)
    begin
      random_seq(q);
      random_seq(t);
      qlen  = 1 + ($unsigned($random(seed)) % sw_pkg::MAX_BASES);
      tlen  = 1 + ($unsigned($random(seed)) % sw_pkg::MAX_BASES);
      score = local_score(q, qlen, t, tlen, CELLS);
      run_job($sformatf("random_be_%0d", n), q, qlen, t, tlen, 1'b0, score, 1'b0);
      run_job($sformatf("random_le_%0d", n), q, qlen, t, tlen, 1'b1, score, 1'b0);
    end

    q = bases_from_text("AGTCCATG");
    t = bases_from_text("AGTCGGCATG");  // Two bases inserted after the fourth
    run_job("gap_insert", q, 8, t, 10, 1'b0, local_score(q, 8, t, 10, CELLS), 1'b0);

    random_seq(q);
    random_seq(t);
    run_job("short_query", q, 3, t, 12, 1'b0, local_score(q, 3, t, 12, CELLS), 1'b0);
    run_job("empty_target", q, 8, t, 0, 1'b0, 0, 1'b0);
    run_job("len_clamp_be", q, 25, t, 25, 1'b0, local_score(q, 25, t, 25, CELLS), 1'b0);
    run_job("len_clamp_le", q, 'h30, t, 'h1234, 1'b1,
            local_score(q, 'h30, t, 'h1234, CELLS), 1'b0);

    random_seq(q);
    random_seq(t);
    run_job("ignored_strobes", q, 8, t, 16, 1'b0, local_score(q, 8, t, 16, CELLS), 1'b1);
    run_job("after_ignored", q, 8, t, 16, 1'b1, local_score(q, 8, t, 16, CELLS), 1'b0);

    repeat (10) @(posedge ha_pclock);  // Room for any stray strobe
    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+bench
hw/sw_pkg.sv
hw/sw_cell.sv
hw/sw_array.sv
hw/seq_sequencer.sv
hw/sw_accel_top.sv
bench/sw_accel_tb.sv
